// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= vectorDisplayTb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) tests/lineModel.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
	  echo "Simulation reported a failure, see $(LOG)"; exit 1; \
	fi
	@grep -q "Test passed" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb.f ====
+incdir+tests
verilog/vectorPkg.sv
verilog/lineQueue.sv
verilog/lineRasterizer.sv
verilog/frameBuffer.sv
verilog/vectorDisplay.sv
tests/vectorDisplayTb.sv

// ==== tests/lineModel.svh ====
`ifndef lineModelSvh
`define lineModelSvh

////////////////////////////////////////////////////////////
// Model frame buffer
////////////////////////////////////////////////////////////

// Expected image with lines plotted in issue order
intensityT modelMem [pixelCount];

// Row major with y selecting the row
function automatic pixelAddrT pixelIndex(input int x, input int y);
  return pixelAddrT'(y * (1 << screenBits) + x);
endfunction

function automatic void clearModel();
  for (int i = 0; i < pixelCount; i++) begin
    modelMem[i] = '0;
  end
endfunction

// Bresenham with the error starting at dx - dy
function automatic void plotLine(input coordT sx, input coordT sy, input coordT ex,
                                 input coordT ey, input intensityT level);
  int x;
  int y;
  int dx;
  int dy;
  int stepX;
  int stepY;
  int err;
  int twoErr;
  bit done;
  x = int'(sx);
  y = int'(sy);
  dx = (ex >= sx) ? int'(ex) - int'(sx) : int'(sx) - int'(ex);
  dy = (ey >= sy) ? int'(ey) - int'(sy) : int'(sy) - int'(ey);
  stepX = (ex >= sx) ? 1 : -1;
  stepY = (ey >= sy) ? 1 : -1;
  err = dx - dy;
  done = 1'b0;
  while (!done) begin
    modelMem[pixelIndex(x, y)] = level;
    if (x == int'(ex) && y == int'(ey)) begin
      done = 1'b1;
    end else begin
      // Both moves judged on the same error
      twoErr = 2 * err;
      if (twoErr >= -dy) begin
        err = err - dy;
        x = x + stepX;
      end
      if (twoErr <= dx) begin
        err = err + dx;
        y = y + stepY;
      end
    end
  end
endfunction

`endif

// ==== tests/vectorDisplayTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vectorDisplayTb
  import vectorPkg::*;
  ();

  localparam int          timeoutCycles = 10000;
  localparam logic [31:0] lfsrSeed      = 32'h40206444;

  logic      clk = 1'b0;
  logic      rst;
  logic      lineWrite;
  coordT     startX;
  coordT     startY;
  coordT     endX;
  coordT     endY;
  intensityT intensity;
  logic      clearStart;
  pixelAddrT rdAddr;
  logic      full;
  logic      clearBusy;
  logic      idle;
  intensityT rdData;

  // Read pipeline seen by the comparing process
  logic        readValid;
  logic        expectValid = 1'b0;
  pixelAddrT   expectAddr;
  int          errorCount = 0;
  logic [31:0] lfsrState;

  `include "lineModel.svh"

  vectorDisplay u_dut (
    .clk        (clk),
    .rst        (rst),
    .lineWrite  (lineWrite),
    .startX     (startX),
    .startY     (startY),
    .endX       (endX),
    .endY       (endY),
    .intensity  (intensity),
    .clearStart (clearStart),
    .rdAddr     (rdAddr),
    .full       (full),
    .clearBusy  (clearBusy),
    .idle       (idle),
    .rdData     (rdData)
  );

  always #10 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Failure reporting and random numbers
  ////////////////////////////////////////////////////////////

  task automatic flagError(input string msg);
    errorCount++;
    $display("error at %0t ns: %s", $time, msg);
    $display("Test failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic abortOnTimeout(input string what);
    $display("Timed out after %0d cycles waiting for %s", timeoutCycles, what);
    $display("Test failed");
    $fatal(1, "simulation timed out");
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
    return value;
  endfunction

  ////////////////////////////////////////////////////////////
  // Waits sampled on the falling edge
  ////////////////////////////////////////////////////////////

  task automatic waitNotFull();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (full) begin
      if (cycles >= timeoutCycles) begin
        abortOnTimeout("the line queue to leave full");
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic waitIdle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (!idle) begin
      if (cycles >= timeoutCycles) begin
        abortOnTimeout("the display to become idle");
      end
      cycles++;
      @(negedge clk);
    end
  endtask

  task automatic finishClear(output int busyCycles);
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (clearBusy) begin
      if (cycles >= timeoutCycles) begin
        abortOnTimeout("the clear sweep to end");
      end
      cycles++;
      @(negedge clk);
    end
    busyCycles = cycles;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // One write strobe with an optional clearStart in the same cycle
  task automatic writeLine(input coordT sx, input coordT sy, input coordT ex,
                           input coordT ey, input intensityT level, input bit withClear);
    waitNotFull();
    @(posedge clk);
    lineWrite  <= 1'b1;
    startX     <= sx;
    startY     <= sy;
    endX       <= ex;
    endY       <= ey;
    intensity  <= level;
    clearStart <= withClear;
    @(posedge clk);
    lineWrite  <= 1'b0;
    clearStart <= 1'b0;
    plotLine(sx, sy, ex, ey, level);
  endtask

  task automatic writeRandomLine(input bit withClear);
    coordT     sx;
    coordT     sy;
    coordT     ex;
    coordT     ey;
    intensityT level;
    sx = coordT'(randomBits(screenBits));
    sy = coordT'(randomBits(screenBits));
    ex = coordT'(randomBits(screenBits));
    ey = coordT'(randomBits(screenBits));
    level = intensityT'(randomBits(intensityBits));
    writeLine(sx, sy, ex, ey, level, withClear);
  endtask

  task automatic clearScreen();
    int busyCycles;
    @(posedge clk);
    clearStart <= 1'b1;
    @(posedge clk);
    clearStart <= 1'b0;
    finishClear(busyCycles);
    assert (busyCycles == pixelCount) else
      flagError($sformatf("clearBusy high for %0d cycles, expected %0d",
                          busyCycles, pixelCount));
    clearModel();
  endtask

  // Back to back reads of one address per cycle
  task automatic readImage(input bit descending);
    for (int i = 0; i < pixelCount; i++) begin
      @(posedge clk);
      rdAddr    <= descending ? pixelAddrT'(pixelCount - 1 - i) : pixelAddrT'(i);
      readValid <= 1'b1;
    end
    @(posedge clk);
    readValid <= 1'b0;
    repeat (2) @(posedge clk);
  endtask

  task automatic drawAndCheck(input coordT sx, input coordT sy, input coordT ex,
                              input coordT ey, input intensityT level);
    writeLine(sx, sy, ex, ey, level, 1'b0);
    waitIdle();
    readImage(1'b0);
  endtask

  ////////////////////////////////////////////////////////////
  // Read data compare one cycle behind rdAddr
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    expectAddr  <= rdAddr;
    expectValid <= readValid;
  end

  always @(negedge clk) begin
    if (expectValid) begin
      assert (rdData === modelMem[expectAddr]) else
        flagError($sformatf("rdData at address %0d is %0h, expected %0h",
                            expectAddr, rdData, modelMem[expectAddr]));
    end
  end

  initial begin
    rst        = 1'b1;
    lineWrite  = 1'b0;
    startX     = '0;
    startY     = '0;
    endX       = '0;
    endY       = '0;
    intensity  = '0;
    clearStart = 1'b0;
    rdAddr     = '0;
    readValid  = 1'b0;
    lfsrState  = lfsrSeed;

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    assert (!full && !clearBusy && idle) else
      flagError($sformatf("after reset full=%b clearBusy=%b idle=%b",
                          full, clearBusy, idle));

    $display("Clear sweep");
    clearScreen();
    readImage(1'b0);

    $display("Directed lines");
    drawAndCheck(6'd5, 6'd10, 6'd40, 6'd10, 4'hf);
    drawAndCheck(6'd20, 6'd3, 6'd20, 6'd50, 4'h9);
    drawAndCheck(6'd0, 6'd0, 6'd63, 6'd63, 4'h5);
    drawAndCheck(6'd33, 6'd33, 6'd33, 6'd33, 4'hc);
    drawAndCheck(6'd2, 6'd40, 6'd61, 6'd47, 4'h3);
    drawAndCheck(6'd10, 6'd60, 6'd55, 6'd20, 4'h7);
    drawAndCheck(6'd60, 6'd5, 6'd8, 6'd30, 4'ha);
    drawAndCheck(6'd50, 6'd50, 6'd3, 6'd12, 4'h1);
    drawAndCheck(6'd30, 6'd2, 6'd36, 6'd62, 4'he);

    $display("Random lines");
    clearScreen();
    for (int i = 0; i < 40; i++) begin
      writeRandomLine(1'b0);
    end
    waitIdle();
    readImage(1'b0);
    readImage(1'b1);

    // First line is still in load when the sweep starts, so the
    // model clears ahead of it
    $display("Clear with lines queued");
    clearModel();
    writeRandomLine(1'b0);
    writeRandomLine(1'b1);
    for (int i = 0; i < 10; i++) begin
      writeRandomLine(1'b0);
    end
    waitIdle();
    readImage(1'b0);

    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/frameBuffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frameBuffer
  import vectorPkg::*;
  (
  input  wire            clk,
  input  wire            rst,
  input  wire            pixelValid,
  input  wire coordT     pixelX,
  input  wire coordT     pixelY,
  input  wire intensityT pixelIntensity,
  input  wire            clearStart,
  input  wire pixelAddrT rdAddr,
  output logic           stall,
  output logic           clearBusy,
  output logic           writePending,
  output intensityT      rdData
  );

  intensityT  mem [pixelCount];

  clearStateT clearState;
  pixelAddrT  clearAddr;

  pixelAddrT  wrAddr;
  intensityT  wrData;
  logic       accept;

  logic       memWe;
  pixelAddrT  memAddr;
  intensityT  memData;

  assign clearBusy = (clearState == clearSweep);
  assign stall     = clearBusy;
  assign accept    = pixelValid && !stall;

  ////////////////////////////////////////////////////////////
  // Pixel write stage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      writePending <= 1'b0;
    end else begin
      writePending <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      wrAddr <= {pixelY, pixelX};
      wrData <= pixelIntensity;
    end
  end

  ////////////////////////////////////////////////////////////
  // Clear sweep
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      clearState <= clearRun;
      clearAddr  <= '0;
    end else begin
      case (clearState)
        clearRun: begin
          if (clearStart) begin
            clearState <= clearSweep;
            clearAddr  <= '0;
          end
        end
        clearSweep: begin
          clearAddr <= clearAddr + 1'b1;
          // Last address reached
          if (&clearAddr) begin
            clearState <= clearRun;
          end
        end
        default: clearState <= clearRun;
      endcase
    end
  end

  // Sweep wins. A pixel pending at sweep start lies in the cleared area anyway
  always_comb begin
    memWe   = clearBusy || writePending;
    memAddr = clearBusy ? clearAddr : wrAddr;
    memData = clearBusy ? intensityT'(0) : wrData;
  end

  always_ff @(posedge clk) begin
    if (memWe) begin
      mem[memAddr] <= memData;
    end
    rdData <= mem[rdAddr];
  end

endmodule

`default_nettype wire

// ==== verilog/lineQueue.sv ====
`timescale 1ns/10ps
`default_nettype none

module lineQueue
  import vectorPkg::*;
  (
  input  wire            clk,
  input  wire            rst,
  input  wire            lineWrite,
  input  wire coordT     startX,
  input  wire coordT     startY,
  input  wire coordT     endX,
  input  wire coordT     endY,
  input  wire intensityT intensity,
  input  wire            lineDone,
  output coordT          qStartX,
  output coordT          qStartY,
  output coordT          qEndX,
  output coordT          qEndY,
  output intensityT      qIntensity,
  output logic           full,
  output logic           empty
  );

  coordT     startXMem    [queueDepth];
  coordT     startYMem    [queueDepth];
  coordT     endXMem      [queueDepth];
  coordT     endYMem      [queueDepth];
  intensityT intensityMem [queueDepth];

  queuePtrT              wrPtr;
  queuePtrT              rdPtr;
  logic [queuePtrBits:0] count;
  logic                  push;
  logic                  pop;

  assign push  = lineWrite && !full;
  assign pop   = lineDone && !empty;
  assign full  = (count == (queuePtrBits + 1)'(queueDepth));
  assign empty = (count == '0);

  // Descriptor storage
  always_ff @(posedge clk) begin
    if (push) begin
      startXMem[wrPtr]    <= startX;
      startYMem[wrPtr]    <= startY;
      endXMem[wrPtr]      <= endX;
      endYMem[wrPtr]      <= endY;
      intensityMem[wrPtr] <= intensity;
    end
  end

  // Depth is a power of two so the pointers wrap on their own
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (push) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head of queue
  assign qStartX    = startXMem[rdPtr];
  assign qStartY    = startYMem[rdPtr];
  assign qEndX      = endXMem[rdPtr];
  assign qEndY      = endYMem[rdPtr];
  assign qIntensity = intensityMem[rdPtr];

  // Writer has to watch full
  noWriteWhenFull: assert property (@(posedge clk) disable iff (rst)
    full |-> !lineWrite);

  // Rasterizer only finishes lines it took from here
  noPopWhenEmpty: assert property (@(posedge clk) disable iff (rst)
    empty |-> !lineDone);

endmodule

`default_nettype wire

// ==== verilog/lineRasterizer.sv ====
`timescale 1ns/10ps
`default_nettype none

module lineRasterizer
  import vectorPkg::*;
  (
  input  wire            clk,
  input  wire            rst,
  input  wire coordT     qStartX,
  input  wire coordT     qStartY,
  input  wire coordT     qEndX,
  input  wire coordT     qEndY,
  input  wire intensityT qIntensity,
  input  wire            empty,
  input  wire            stall,
  output logic           lineDone,
  output logic           pixelValid,
  output coordT          pixelX,
  output coordT          pixelY,
  output intensityT      pixelIntensity
  );

  rastStateT state;

  // Current line
  coordT     curX;
  coordT     curY;
  coordT     endX;
  coordT     endY;
  intensityT curIntensity;
  coordT     dx;
  coordT     dy;
  logic      stepXNeg;
  logic      stepYNeg;
  errT       err;

  // Load values from the queue head
  coordT     loadDx;
  coordT     loadDy;
  errT       loadErr;

  // Step decision
  errT       dxErr;
  errT       dyErr;
  errT       twoErr;
  errT       errNext;
  logic      moveX;
  logic      moveY;
  logic      atEnd;
  logic      advance;

  ////////////////////////////////////////////////////////////
  // Line setup
  ////////////////////////////////////////////////////////////

  always_comb begin
    loadDx  = (qEndX >= qStartX) ? qEndX - qStartX : qStartX - qEndX;
    loadDy  = (qEndY >= qStartY) ? qEndY - qStartY : qStartY - qEndY;
    loadErr = errT'({{(errBits - screenBits){1'b0}}, loadDx})
            - errT'({{(errBits - screenBits){1'b0}}, loadDy});
  end

  ////////////////////////////////////////////////////////////
  // Bresenham step
  ////////////////////////////////////////////////////////////

  assign dxErr  = errT'({{(errBits - screenBits){1'b0}}, dx});
  assign dyErr  = errT'({{(errBits - screenBits){1'b0}}, dy});
  assign twoErr = errT'(err <<< 1);

  always_comb begin
    moveX   = (twoErr >= -dyErr);
    moveY   = (twoErr <= dxErr);
    errNext = err;
    if (moveX) begin
      errNext = errNext - dyErr;
    end
    if (moveY) begin
      errNext = errNext + dxErr;
    end
  end

  assign atEnd   = (curX == endX) && (curY == endY);
  assign advance = (state == rastDraw) && !stall;

  // Current point is the output and holds while stalled
  assign pixelValid     = (state == rastDraw);
  assign pixelX         = curX;
  assign pixelY         = curY;
  assign pixelIntensity = curIntensity;
  assign lineDone       = advance && atEnd;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= rastIdle;
    end else begin
      case (state)
        rastIdle: begin
          if (!empty) begin
            state <= rastLoad;
          end
        end
        rastLoad: state <= rastDraw;
        rastDraw: begin
          if (lineDone) begin
            state <= rastIdle;
          end
        end
        default: state <= rastIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rastLoad) begin
      curX         <= qStartX;
      curY         <= qStartY;
      endX         <= qEndX;
      endY         <= qEndY;
      curIntensity <= qIntensity;
      dx           <= loadDx;
      dy           <= loadDy;
      stepXNeg     <= (qEndX < qStartX);
      stepYNeg     <= (qEndY < qStartY);
      err          <= loadErr;
    end else if (advance && !atEnd) begin
      if (moveX) begin
        curX <= stepXNeg ? curX - 1'b1 : curX + 1'b1;
      end
      if (moveY) begin
        curY <= stepYNeg ? curY - 1'b1 : curY + 1'b1;
      end
      err <= errNext;
    end
  end

  // Draw is entered only through load
  pixelOnlyInDraw: assert property (@(posedge clk) disable iff (rst)
    pixelValid |-> $past(state == rastLoad) || $past(pixelValid));

  // Frame buffer stall must not lose or move a pixel
  stallHoldsPixel: assert property (@(posedge clk) disable iff (rst)
    pixelValid && stall |=> pixelValid && $stable(pixelX) && $stable(pixelY));

endmodule

`default_nettype wire

// ==== verilog/vectorDisplay.sv ====
`timescale 1ns/10ps
`default_nettype none

module vectorDisplay
  import vectorPkg::*;
  (
  input  wire            clk,
  input  wire            rst,
  input  wire            lineWrite,
  input  wire coordT     startX,
  input  wire coordT     startY,
  input  wire coordT     endX,
  input  wire coordT     endY,
  input  wire intensityT intensity,
  input  wire            clearStart,
  input  wire pixelAddrT rdAddr,
  output logic           full,
  output logic           clearBusy,
  output logic           idle,
  output intensityT      rdData
  );

  // Queue head
  coordT     qStartX;
  coordT     qStartY;
  coordT     qEndX;
  coordT     qEndY;
  intensityT qIntensity;
  logic      empty;
  logic      lineDone;

  // Pixel stream
  logic      pixelValid;
  coordT     pixelX;
  coordT     pixelY;
  intensityT pixelIntensity;
  logic      stall;
  logic      writePending;

  lineQueue lineQueueInst (
    .clk        (clk),
    .rst        (rst),
    .lineWrite  (lineWrite),
    .startX     (startX),
    .startY     (startY),
    .endX       (endX),
    .endY       (endY),
    .intensity  (intensity),
    .lineDone   (lineDone),
    .qStartX    (qStartX),
    .qStartY    (qStartY),
    .qEndX      (qEndX),
    .qEndY      (qEndY),
    .qIntensity (qIntensity),
    .full       (full),
    .empty      (empty)
  );

  lineRasterizer lineRasterizerInst (
    .clk            (clk),
    .rst            (rst),
    .qStartX        (qStartX),
    .qStartY        (qStartY),
    .qEndX          (qEndX),
    .qEndY          (qEndY),
    .qIntensity     (qIntensity),
    .empty          (empty),
    .stall          (stall),
    .lineDone       (lineDone),
    .pixelValid     (pixelValid),
    .pixelX         (pixelX),
    .pixelY         (pixelY),
    .pixelIntensity (pixelIntensity)
  );

  frameBuffer frameBufferInst (
    .clk            (clk),
    .rst            (rst),
    .pixelValid     (pixelValid),
    .pixelX         (pixelX),
    .pixelY         (pixelY),
    .pixelIntensity (pixelIntensity),
    .clearStart     (clearStart),
    .rdAddr         (rdAddr),
    .stall          (stall),
    .clearBusy      (clearBusy),
    .writePending   (writePending),
    .rdData         (rdData)
  );

  // Rasterizer leaves idle only for a non-empty queue, then shows pixels
  // until it returns, so no pixel plus empty queue means it is idle
  assign idle = empty && !pixelValid && !writePending && !clearBusy;

endmodule

`default_nettype wire

// ==== verilog/vectorPkg.sv ====
`default_nettype none

package vectorPkg;

  ////////////////////////////////////////////////////////////
  // Screen and queue sizes
  ////////////////////////////////////////////////////////////

  localparam int screenBits    = 6;
  localparam int intensityBits = 4;
  localparam int queueDepth    = 8;

  // Derived widths
  localparam int queuePtrBits = $clog2(queueDepth);
  localparam int addrBits     = 2 * screenBits;
  localparam int pixelCount   = 1 << addrBits;

  // Room for twice the Bresenham error with sign
  localparam int errBits = screenBits + 4;

  ////////////////////////////////////////////////////////////
  // Vector types
  ////////////////////////////////////////////////////////////

  typedef logic [screenBits-1:0]    coordT;
  typedef logic [intensityBits-1:0] intensityT;

  // Row major with y in the upper half
  typedef logic [addrBits-1:0]      pixelAddrT;

  typedef logic [queuePtrBits-1:0]  queuePtrT;
  typedef logic signed [errBits-1:0] errT;

  typedef enum logic [1:0] {
    rastIdle,
    rastLoad,
    rastDraw
  } rastStateT;

  typedef enum logic {
    clearRun,
    clearSweep
  } clearStateT;

endpackage

`default_nettype wire
